// ==== decode_pkg.sv ====
package decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } j_fmt_t;

    // One instruction word, seen through each of the base formats.
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

endpackage

// ==== decode_register.sv ====
`timescale 1ns/1ps

module decode_register #(
    parameter int CNT_WIDTH = 8
) (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              instr_valid_i,
    input  logic                              invalid_instruction_i,
    input  logic                              is_unconditional_jump_i,
    input  logic                              is_conditional_jump_i,
    input  logic [decode_pkg::XLEN-1:0]       imm_i,
    input  logic [decode_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic [decode_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [decode_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic                              mem_read_i,
    input  logic                              mem_write_i,
    input  logic                              reg_write_i,
    input  logic                              csr_op_i,
    input  logic                              atomic_op_i,
    input  logic [2:0]                        mem_size_i,
    output logic                              valid_o,
    output logic                              trap_o,
    output logic                              invalid_instruction_o,
    output logic                              is_unconditional_jump_o,
    output logic                              is_conditional_jump_o,
    output logic [decode_pkg::XLEN-1:0]       imm_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs2_o,
    output logic                              mem_read_o,
    output logic                              mem_write_o,
    output logic                              reg_write_o,
    output logic                              csr_op_o,
    output logic                              atomic_op_o,
    output logic [2:0]                        mem_size_o,
    output logic [CNT_WIDTH-1:0]              illegal_count_o
);

    logic illegal_seen;

    assign illegal_seen = instr_valid_i && invalid_instruction_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o         <= 1'b0;
            trap_o          <= 1'b0;
            illegal_count_o <= '0;
        end else begin
            valid_o <= instr_valid_i;
            trap_o  <= illegal_seen; // One pulse per illegal word, aligned with valid_o.
            if (illegal_seen && (illegal_count_o != '1)) begin
                illegal_count_o <= illegal_count_o + 1'b1;
            end
        end
    end

    // Outputs hold the last decoded instruction between strobes.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            invalid_instruction_o   <= 1'b0;
            is_unconditional_jump_o <= 1'b0;
            is_conditional_jump_o   <= 1'b0;
            imm_o                   <= '0;
            rd_o                    <= '0;
            rs1_o                   <= '0;
            rs2_o                   <= '0;
            mem_read_o              <= 1'b0;
            mem_write_o             <= 1'b0;
            reg_write_o             <= 1'b0;
            csr_op_o                <= 1'b0;
            atomic_op_o             <= 1'b0;
            mem_size_o              <= 3'b000;
        end else if (instr_valid_i) begin
            invalid_instruction_o   <= invalid_instruction_i;
            is_unconditional_jump_o <= is_unconditional_jump_i;
            is_conditional_jump_o   <= is_conditional_jump_i;
            imm_o                   <= imm_i;
            rd_o                    <= rd_i;
            rs1_o                   <= rs1_i;
            rs2_o                   <= rs2_i;
            mem_read_o              <= mem_read_i;
            mem_write_o             <= mem_write_i;
            reg_write_o             <= reg_write_i;
            csr_op_o                <= csr_op_i;
            atomic_op_o             <= atomic_op_i;
            mem_size_o              <= mem_size_i;
        end
    end

    a_trap_with_valid: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) trap_o |-> valid_o
    );

    // The count only moves up once reset has been released for a cycle.
    a_count_monotonic: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $past(rst_n_i) |-> (illegal_count_o >= $past(illegal_count_o))
    );

    a_jump_exclusive: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(is_unconditional_jump_o && is_conditional_jump_o)
    );

endmodule

// ==== imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen (
    input  decode_pkg::instr_u              instruction_i,
    output logic [decode_pkg::XLEN-1:0]     imm_o
);

    import opcodes_pkg::*;
    import decode_pkg::*;

    always_comb begin
        imm_o = '0;

        case (instruction_i.r_fmt.opcode)
            LW_OPCODE, JALR_OPCODE, IMMEDIATE_OPCODE, CSR_OPCODE: begin
                imm_o = {{(XLEN-12){instruction_i.i_fmt.imm_11_0[11]}},
                         instruction_i.i_fmt.imm_11_0};
            end
            SW_OPCODE: begin
                imm_o = {{(XLEN-12){instruction_i.s_fmt.imm_11_5[6]}},
                         instruction_i.s_fmt.imm_11_5,
                         instruction_i.s_fmt.imm_4_0};
            end
            BRANCH_OPCODE: begin
                imm_o = {{(XLEN-12){instruction_i.b_fmt.imm_12}},
                         instruction_i.b_fmt.imm_11,
                         instruction_i.b_fmt.imm_10_5,
                         instruction_i.b_fmt.imm_4_1,
                         1'b0}; // Branch targets are halfword aligned.
            end
            LUI_OPCODE, AUIPC_OPCODE: begin
                imm_o = {instruction_i.u_fmt.imm_31_12, 12'b0};
            end
            JAL_OPCODE: begin
                imm_o = {{(XLEN-20){instruction_i.j_fmt.imm_20}},
                         instruction_i.j_fmt.imm_19_12,
                         instruction_i.j_fmt.imm_11,
                         instruction_i.j_fmt.imm_10_1,
                         1'b0};
            end
            default: imm_o = '0;
        endcase
    end

endmodule

// ==== instr_fields_decoder.sv ====
`timescale 1ns/1ps

module instr_fields_decoder (
    input  decode_pkg::instr_u                instruction_i,
    output logic [decode_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs2_o,
    output logic                              mem_read_o,
    output logic                              mem_write_o,
    output logic                              reg_write_o,
    output logic                              csr_op_o,
    output logic                              atomic_op_o,
    output logic [2:0]                        mem_size_o
);

    import opcodes_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] funct5;

    assign opcode = instruction_i.r_fmt.opcode;
    assign funct3 = instruction_i.r_fmt.funct3;
    assign funct5 = instruction_i.r_fmt.funct7[6:2];

    always_comb begin
        rd_o  = instruction_i.r_fmt.rd;
        rs1_o = instruction_i.r_fmt.rs1;
        rs2_o = '0;

        case (opcode)
            SW_OPCODE, BRANCH_OPCODE: begin
                rd_o  = '0; // These formats carry immediate bits where rd would be.
                rs2_o = instruction_i.r_fmt.rs2;
            end
            RTYPE_OPCODE, ATOMIC_OPCODE: rs2_o = instruction_i.r_fmt.rs2;
            LUI_OPCODE, AUIPC_OPCODE, JAL_OPCODE: rs1_o = '0;
            default: ;
        endcase
    end

    always_comb begin
        mem_read_o  = 1'b0;
        mem_write_o = 1'b0;
        mem_size_o  = 3'b000;
        csr_op_o    = 1'b0;
        atomic_op_o = 1'b0;

        case (opcode)
            LW_OPCODE: begin
                mem_read_o = 1'b1;
                mem_size_o = funct3;
            end
            SW_OPCODE: begin
                mem_write_o = 1'b1;
                mem_size_o  = funct3;
            end
            ATOMIC_OPCODE: begin
                atomic_op_o = 1'b1;
                mem_read_o  = 1'b1;
                mem_write_o = (funct5 != LR_FUNCT5); // SC and the AMOs store.
                mem_size_o  = funct3;
            end
            CSR_OPCODE: csr_op_o = (funct3 != 3'b000);
            default: ;
        endcase
    end

    // rd_o is already zero for stores and branches.
    assign reg_write_o = (rd_o != '0);

endmodule

// ==== invalid_ir_check.sv ====
`timescale 1ns/1ps

module invalid_ir_check (
    input  decode_pkg::instr_u instruction_i,
    output logic               invalid_instruction_o,
    output logic               is_unconditional_jump_o,
    output logic               is_conditional_jump_o
);

    import opcodes_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = instruction_i.r_fmt.opcode;
    assign funct3 = instruction_i.r_fmt.funct3;

    always_comb begin
        invalid_instruction_o   = 1'b0;
        is_unconditional_jump_o = 1'b0;
        is_conditional_jump_o   = 1'b0;

        case (opcode)
            LW_OPCODE:  invalid_instruction_o = !LW_FUNCT3_LEGAL[funct3];
            SW_OPCODE:  invalid_instruction_o = !SW_FUNCT3_LEGAL[funct3];
            CSR_OPCODE: invalid_instruction_o = !CSR_FUNCT3_LEGAL[funct3];
            JAL_OPCODE: begin
                is_unconditional_jump_o = 1'b1;
            end
            JALR_OPCODE: begin
                is_conditional_jump_o = 1'b1; // Flag follows the opcode even if funct3 is bad.
                invalid_instruction_o = !JALR_FUNCT3_LEGAL[funct3];
            end
            BRANCH_OPCODE: begin
                is_conditional_jump_o = 1'b1;
                invalid_instruction_o = !BRANCH_FUNCT3_LEGAL[funct3];
            end
            AUIPC_OPCODE, IMMEDIATE_OPCODE, RTYPE_OPCODE, ATOMIC_OPCODE, LUI_OPCODE: begin
                invalid_instruction_o = 1'b0;
            end
            default: invalid_instruction_o = 1'b1;
        endcase
    end

endmodule

// ==== opcodes_pkg.sv ====
package opcodes_pkg;

    localparam logic [6:0] LW_OPCODE        = 7'b0000011;
    localparam logic [6:0] SW_OPCODE        = 7'b0100011;
    localparam logic [6:0] JAL_OPCODE       = 7'b1101111;
    localparam logic [6:0] JALR_OPCODE      = 7'b1100111;
    localparam logic [6:0] CSR_OPCODE       = 7'b1110011;
    localparam logic [6:0] AUIPC_OPCODE     = 7'b0010111;
    localparam logic [6:0] BRANCH_OPCODE    = 7'b1100011;
    localparam logic [6:0] IMMEDIATE_OPCODE = 7'b0010011;
    localparam logic [6:0] RTYPE_OPCODE     = 7'b0110011;
    localparam logic [6:0] ATOMIC_OPCODE    = 7'b0101111;
    localparam logic [6:0] LUI_OPCODE       = 7'b0110111;

    // Legal funct3 sets, one bit per funct3 value.
    localparam logic [7:0] LW_FUNCT3_LEGAL     = 8'b0011_0111; // 0, 1, 2, 4 and 5.
    localparam logic [7:0] SW_FUNCT3_LEGAL     = 8'b0000_0111; // 0, 1 and 2.
    localparam logic [7:0] CSR_FUNCT3_LEGAL    = 8'b0111_0111; // 0 to 6 except 3.
    localparam logic [7:0] JALR_FUNCT3_LEGAL   = 8'b0000_0001;
    localparam logic [7:0] BRANCH_FUNCT3_LEGAL = 8'b1111_0011; // 2 and 3 are unused.

    // Load-reserved is the only AMO that does not write memory.
    localparam logic [4:0] LR_FUNCT5 = 5'b00010;

endpackage

// ==== rv_decode.f ====
opcodes_pkg.sv
decode_pkg.sv
invalid_ir_check.sv
imm_gen.sv
instr_fields_decoder.sv
decode_register.sv
rv_decode_top.sv
tb_rv_decode_top.sv

// ==== rv_decode_top.sv ====
`timescale 1ns/1ps

module rv_decode_top #(
    parameter int CNT_WIDTH = 8
) (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              instr_valid_i,
    input  logic [decode_pkg::XLEN-1:0]       instruction_i,
    output logic                              valid_o,
    output logic                              trap_o,
    output logic                              invalid_instruction_o,
    output logic                              is_unconditional_jump_o,
    output logic                              is_conditional_jump_o,
    output logic [decode_pkg::XLEN-1:0]       imm_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs2_o,
    output logic                              mem_read_o,
    output logic                              mem_write_o,
    output logic [2:0]                        mem_size_o,
    output logic                              reg_write_o,
    output logic                              csr_op_o,
    output logic                              atomic_op_o,
    output logic [CNT_WIDTH-1:0]              illegal_count_o
);

    import decode_pkg::*;

    logic                  invalid_instruction;
    logic                  is_unconditional_jump;
    logic                  is_conditional_jump;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic                  mem_read;
    logic                  mem_write;
    logic                  reg_write;
    logic                  csr_op;
    logic                  atomic_op;
    logic [2:0]            mem_size;

    invalid_ir_check u_invalid_ir_check (
        .instruction_i           (instruction_i),
        .invalid_instruction_o   (invalid_instruction),
        .is_unconditional_jump_o (is_unconditional_jump),
        .is_conditional_jump_o   (is_conditional_jump)
    );

    imm_gen u_imm_gen (
        .instruction_i (instruction_i),
        .imm_o         (imm)
    );

    instr_fields_decoder u_instr_fields_decoder (
        .instruction_i (instruction_i),
        .rd_o          (rd),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .mem_read_o    (mem_read),
        .mem_write_o   (mem_write),
        .reg_write_o   (reg_write),
        .csr_op_o      (csr_op),
        .atomic_op_o   (atomic_op),
        .mem_size_o    (mem_size)
    );

    decode_register #(
        .CNT_WIDTH (CNT_WIDTH)
    ) u_decode_register (
        .clk_i                   (clk_i),
        .rst_n_i                 (rst_n_i),
        .instr_valid_i           (instr_valid_i),
        .invalid_instruction_i   (invalid_instruction),
        .is_unconditional_jump_i (is_unconditional_jump),
        .is_conditional_jump_i   (is_conditional_jump),
        .imm_i                   (imm),
        .rd_i                    (rd),
        .rs1_i                   (rs1),
        .rs2_i                   (rs2),
        .mem_read_i              (mem_read),
        .mem_write_i             (mem_write),
        .reg_write_i             (reg_write),
        .csr_op_i                (csr_op),
        .atomic_op_i             (atomic_op),
        .mem_size_i              (mem_size),
        .valid_o                 (valid_o),
        .trap_o                  (trap_o),
        .invalid_instruction_o   (invalid_instruction_o),
        .is_unconditional_jump_o (is_unconditional_jump_o),
        .is_conditional_jump_o   (is_conditional_jump_o),
        .imm_o                   (imm_o),
        .rd_o                    (rd_o),
        .rs1_o                   (rs1_o),
        .rs2_o                   (rs2_o),
        .mem_read_o              (mem_read_o),
        .mem_write_o             (mem_write_o),
        .reg_write_o             (reg_write_o),
        .csr_op_o                (csr_op_o),
        .atomic_op_o             (atomic_op_o),
        .mem_size_o              (mem_size_o),
        .illegal_count_o         (illegal_count_o)
    );

endmodule

// ==== tb_rv_decode_top.sv ====
`timescale 1ns/1ps

module tb_rv_decode_top;

    import opcodes_pkg::*;
    import decode_pkg::*;

    localparam int CNT_WIDTH      = 4;
    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 5;
    localparam int N_COUNT_ROUNDS = 18;
    localparam int N_LEGAL        = 11 * 8;
    localparam int N_IMM          = 200;
    localparam int N_FIELDS       = 14;
    localparam int N_RANDOM       = 300;
    // Each counter round is an illegal word, a legal word and an idle slot.
    localparam int TOTAL_SLOTS    = RESET_CYCLES + 3 * N_COUNT_ROUNDS + N_LEGAL + N_IMM
                                    + N_FIELDS + N_RANDOM;

    typedef struct packed {
        logic                  invalid;
        logic                  ujump;
        logic                  cjump;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  mem_read;
        logic                  mem_write;
        logic                  reg_write;
        logic                  csr_op;
        logic                  atomic_op;
        logic [2:0]            mem_size;
    } expect_t;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  instr_valid_i;
    logic [XLEN-1:0]       instruction_i;
    logic                  valid_o;
    logic                  trap_o;
    logic                  invalid_instruction_o;
    logic                  is_unconditional_jump_o;
    logic                  is_conditional_jump_o;
    logic [XLEN-1:0]       imm_o;
    logic [REG_ADDR_W-1:0] rd_o;
    logic [REG_ADDR_W-1:0] rs1_o;
    logic [REG_ADDR_W-1:0] rs2_o;
    logic                  mem_read_o;
    logic                  mem_write_o;
    logic [2:0]            mem_size_o;
    logic                  reg_write_o;
    logic                  csr_op_o;
    logic                  atomic_op_o;
    logic [CNT_WIDTH-1:0]  illegal_count_o;

    expect_t expect_q[$];
    string   name_q[$];

    rv_decode_top #(.CNT_WIDTH(CNT_WIDTH)) dut (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Expected decode of one word, built from the instruction set rules.
    function automatic expect_t expected_decode(input logic [XLEN-1:0] w);
        expect_t    e;
        logic [6:0] op;
        logic [2:0] f3;
        e   = '0;
        op  = w[6:0];
        f3  = w[14:12];
        e.rd  = w[11:7];
        e.rs1 = w[19:15];
        case (op)
            LW_OPCODE: begin
                e.invalid  = !(f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
                e.imm      = {{20{w[31]}}, w[31:20]};
                e.mem_read = 1'b1;
                e.mem_size = f3;
            end
            SW_OPCODE: begin
                e.invalid   = !(f3 inside {3'd0, 3'd1, 3'd2});
                e.imm       = {{20{w[31]}}, w[31:25], w[11:7]};
                e.rd        = '0;
                e.rs2       = w[24:20];
                e.mem_write = 1'b1;
                e.mem_size  = f3;
            end
            CSR_OPCODE: begin
                e.invalid = !(f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5, 3'd6});
                e.imm     = {{20{w[31]}}, w[31:20]};
                e.csr_op  = (f3 != 3'd0);
            end
            JALR_OPCODE: begin
                e.invalid = (f3 != 3'd0);
                e.cjump   = 1'b1;
                e.imm     = {{20{w[31]}}, w[31:20]};
            end
            BRANCH_OPCODE: begin
                e.invalid = !(f3 inside {3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7});
                e.cjump   = 1'b1;
                e.imm     = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                e.rd      = '0;
                e.rs2     = w[24:20];
            end
            JAL_OPCODE: begin
                e.ujump = 1'b1;
                e.imm   = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                e.rs1   = '0;
            end
            LUI_OPCODE, AUIPC_OPCODE: begin
                e.imm = {w[31:12], 12'h000};
                e.rs1 = '0;
            end
            IMMEDIATE_OPCODE: e.imm = {{20{w[31]}}, w[31:20]};
            RTYPE_OPCODE:     e.rs2 = w[24:20];
            ATOMIC_OPCODE: begin
                e.rs2       = w[24:20];
                e.mem_read  = 1'b1;
                e.mem_write = (w[31:27] != 5'b00010); // LR only reads.
                e.mem_size  = f3;
                e.atomic_op = 1'b1;
            end
            default: e.invalid = 1'b1;
        endcase
        e.reg_write = !(op inside {SW_OPCODE, BRANCH_OPCODE}) && (w[11:7] != 5'd0);
        return e;
    endfunction

    function automatic logic [6:0] pick_opcode(input int idx);
        case (idx)
            0:       return LW_OPCODE;
            1:       return SW_OPCODE;
            2:       return JAL_OPCODE;
            3:       return JALR_OPCODE;
            4:       return CSR_OPCODE;
            5:       return AUIPC_OPCODE;
            6:       return BRANCH_OPCODE;
            7:       return IMMEDIATE_OPCODE;
            8:       return RTYPE_OPCODE;
            9:       return ATOMIC_OPCODE;
            default: return LUI_OPCODE;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] make_word(input logic [6:0] opcode,
                                                  input logic [2:0] funct3);
        instr_u w;
        w              = $urandom;
        w.r_fmt.opcode = opcode;
        w.r_fmt.funct3 = funct3;
        return w;
    endfunction

    function automatic logic [XLEN-1:0] make_fields(input logic [6:0] opcode,
            input logic [6:0] funct7, input logic [4:0] rs2, input logic [4:0] rs1,
            input logic [2:0] funct3, input logic [4:0] rd);
        instr_u w;
        w.r_fmt.funct7 = funct7;
        w.r_fmt.rs2    = rs2;
        w.r_fmt.rs1    = rs1;
        w.r_fmt.funct3 = funct3;
        w.r_fmt.rd     = rd;
        w.r_fmt.opcode = opcode;
        return w;
    endfunction

    task automatic report_mismatch(input string name, input string what,
                                   input logic [XLEN-1:0] expected,
                                   input logic [XLEN-1:0] actual);
        $display("CHECK FAILED test=%s signal=%s expected=0x%0h actual=0x%0h",
                 name, what, expected, actual);
        $display("Regression failed");
        $fatal(1, "Stopped at the first mismatch.");
    endtask

    task automatic check_bit(input string name, input string what,
                             input logic expected, input logic actual);
        if (actual !== expected) report_mismatch(name, what, expected, actual);
    endtask

    task automatic check_addr(input string name, input string what,
                              input logic [REG_ADDR_W-1:0] expected,
                              input logic [REG_ADDR_W-1:0] actual);
        if (actual !== expected) report_mismatch(name, what, expected, actual);
    endtask

    task automatic check_word(input string name, input string what,
                              input logic [XLEN-1:0] expected, input logic [XLEN-1:0] actual);
        if (actual !== expected) report_mismatch(name, what, expected, actual);
    endtask

    task automatic check_count(input string name, input string what,
                               input logic [CNT_WIDTH-1:0] expected,
                               input logic [CNT_WIDTH-1:0] actual);
        if (actual !== expected) report_mismatch(name, what, expected, actual);
    endtask

    task automatic check_record(input string name, input expect_t e);
        check_bit(name, "invalid_instruction_o", e.invalid, invalid_instruction_o);
        check_bit(name, "is_unconditional_jump_o", e.ujump, is_unconditional_jump_o);
        check_bit(name, "is_conditional_jump_o", e.cjump, is_conditional_jump_o);
        check_word(name, "imm_o", e.imm, imm_o);
        check_addr(name, "rd_o", e.rd, rd_o);
        check_addr(name, "rs1_o", e.rs1, rs1_o);
        check_addr(name, "rs2_o", e.rs2, rs2_o);
        check_bit(name, "mem_read_o", e.mem_read, mem_read_o);
        check_bit(name, "mem_write_o", e.mem_write, mem_write_o);
        check_addr(name, "mem_size_o", e.mem_size, mem_size_o); // Zero-extended to 5 bits.
        check_bit(name, "reg_write_o", e.reg_write, reg_write_o);
        check_bit(name, "csr_op_o", e.csr_op, csr_op_o);
        check_bit(name, "atomic_op_o", e.atomic_op, atomic_op_o);
    endtask

    // One slot of stimulus, driven just after the rising edge.
    task automatic issue(input logic valid, input logic [XLEN-1:0] word, input string name);
        @(posedge clk_i);
        #1;
        instr_valid_i = valid;
        instruction_i = word;
        if (valid) begin
            expect_q.push_back(expected_decode(word));
            name_q.push_back(name);
        end
    endtask

    initial begin : compare_outputs
        expect_t              held;
        logic                 exp_valid;
        string                name;
        logic [CNT_WIDTH-1:0] sw_count;
        held     = '0;
        sw_count = '0;
        name     = "reset";
        wait (rst_n_i === 1'b1);
        forever begin
            @(posedge clk_i);
            exp_valid = instr_valid_i; // Stable here, the driver moves it 1 ns later.
            if (exp_valid) begin
                held = expect_q.pop_front();
                name = name_q.pop_front();
                if (held.invalid && sw_count != 4'd15) sw_count = sw_count + 1'b1;
            end
            @(negedge clk_i);
            check_bit(name, "valid_o", exp_valid, valid_o);
            check_bit(name, "trap_o", exp_valid && held.invalid, trap_o);
            check_count(name, "illegal_count_o", sw_count, illegal_count_o);
            check_record(name, held); // Idle cycles must hold the last record.
        end
    end

    initial begin
        #((TOTAL_SLOTS + 20) * CLK_PERIOD);
        $display("Watchdog expired: the decode run hung before all tests finished.");
        $display("Regression failed");
        $fatal(1, "Simulation stopped by the watchdog.");
    end

    initial begin
        void'($urandom(86));
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instruction_i = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        check_bit("reset", "valid_o", 1'b0, valid_o);
        check_bit("reset", "trap_o", 1'b0, trap_o);
        check_count("reset", "illegal_count_o", '0, illegal_count_o);
        check_record("reset", '0);

        // Counter first, while it still starts from zero.
        for (int i = 0; i < N_COUNT_ROUNDS; i++) begin
            issue(1'b1, make_word((i % 2) ? 7'h7f : 7'h00, $urandom), "counter");
            issue(1'b1, make_word(pick_opcode($urandom_range(10)), 3'd0), "counter");
            issue(1'b0, $urandom, "counter");
        end
        @(negedge clk_i);
        check_count("counter saturation", "illegal_count_o", 15, illegal_count_o);

        for (int op = 0; op < 11; op++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                issue(1'b1, make_word(pick_opcode(op), f3), "legality table");
            end
        end

        for (int i = 0; i < N_IMM; i++) begin
            issue(1'b1, make_word(pick_opcode($urandom_range(10)), $urandom), "immediates");
        end

        issue(1'b1, make_fields(ATOMIC_OPCODE, 7'b0001000, 5'd0, 5'd6, 3'd2, 5'd5), "fields LR");
        issue(1'b1, make_fields(ATOMIC_OPCODE, 7'b0001100, 5'd7, 5'd6, 3'd2, 5'd5), "fields SC");
        issue(1'b1, make_fields(ATOMIC_OPCODE, 7'b0000000, 5'd9, 5'd8, 3'd2, 5'd1), "fields AMO");
        issue(1'b1, make_fields(ATOMIC_OPCODE, 7'b0000111, 5'd3, 5'd4, 3'd2, 5'd0), "fields AMO");
        issue(1'b1, make_fields(LW_OPCODE, 7'h12, 5'd3, 5'd4, 3'd2, 5'd0), "fields rd zero");
        issue(1'b1, make_fields(IMMEDIATE_OPCODE, 7'h40, 5'd1, 5'd2, 3'd0, 5'd0),
              "fields rd zero");
        issue(1'b1, make_fields(CSR_OPCODE, 7'h18, 5'd2, 5'd0, 3'd0, 5'd0), "fields CSR zero");
        issue(1'b1, make_fields(CSR_OPCODE, 7'h18, 5'd0, 5'd3, 3'd1, 5'd4), "fields CSR");
        issue(1'b1, make_fields(SW_OPCODE, 7'h7f, 5'd10, 5'd11, 3'd2, 5'd31), "fields SW");
        issue(1'b1, make_fields(BRANCH_OPCODE, 7'h55, 5'd12, 5'd13, 3'd1, 5'd17),
              "fields BRANCH");
        issue(1'b1, make_fields(RTYPE_OPCODE, 7'h20, 5'd14, 5'd15, 3'd0, 5'd31), "fields RTYPE");
        issue(1'b1, make_fields(LUI_OPCODE, 7'h2a, 5'd16, 5'd19, 3'd5, 5'd2), "fields LUI");
        issue(1'b1, make_fields(JAL_OPCODE, 7'h01, 5'd20, 5'd21, 3'd3, 5'd1), "fields JAL");
        issue(1'b1, make_fields(AUIPC_OPCODE, 7'h7e, 5'd22, 5'd23, 3'd7, 5'd8), "fields AUIPC");

        for (int i = 0; i < N_RANDOM; i++) begin
            issue(1'b1, $urandom, "random words");
        end

        issue(1'b0, '0, "drain");
        issue(1'b0, '0, "drain");
        @(negedge clk_i);
        #10;
        $display("Regression passed");
        $finish;
    end

endmodule
